// File: hw/busy_track_settings.svh
`ifndef BUSY_TRACK_SETTINGS_SVH
`define BUSY_TRACK_SETTINGS_SVH

// Physical register file size of the integer core
`define BT_PREG_NUM 64

// Address width of one physical register
`define BT_PREG_W   6

// Dispatch width with two sources per slot
`define BT_SLOTS    2

`endif

// File: hw/busy_track_pkg.sv
`include "busy_track_settings.svh"

package busy_track_pkg;

    // Reorder buffer recovery state as seen by rename
    typedef enum logic [1:0] {
        ROB_IDLE     = 2'b00,
        ROB_ROLLBACK = 2'b01,  // Clears the whole table
        ROB_WALK     = 2'b10   // Replays entries that were not yet complete
    } rob_state_e;

    // One allocate or free strobe
    typedef struct packed {
        logic                  en;
        logic [`BT_PREG_W-1:0] addr;
    } preg_upd_t;

    // One entry walked out of the reorder buffer
    typedef struct packed {
        logic                  valid;
        logic                  complete;  // Result already written back
        logic [`BT_PREG_W-1:0] prd;
    } walk_ent_t;

    // Source side of one dispatch slot
    typedef struct packed {
        logic                  valid;
        logic                  rs1_use;
        logic [`BT_PREG_W-1:0] rs1;
        logic                  rs2_use;
        logic [`BT_PREG_W-1:0] rs2;
    } disp_slot_t;

    // Address presented to one lookup port
    typedef struct packed {
        logic [`BT_PREG_W-1:0] addr;
    } src_query_t;

endpackage

// File: hw/busy_vector.sv
`include "busy_track_settings.svh"

module busy_vector (
    input  logic                                      clock,
    input  logic                                      rst,
    input  busy_track_pkg::preg_upd_t [`BT_SLOTS-1:0] alloc,
    input  busy_track_pkg::preg_upd_t                 free_int,
    input  busy_track_pkg::preg_upd_t                 free_mem,
    input  busy_track_pkg::rob_state_e                rob_state,
    input  busy_track_pkg::walk_ent_t [`BT_SLOTS-1:0] walk,
    output logic [`BT_PREG_NUM-1:0]                   busy_q
);
    import busy_track_pkg::*;

    logic                    is_rollback;
    logic [`BT_PREG_NUM-1:0] alloc_set;   // Bits set by dispatch
    logic [`BT_PREG_NUM-1:0] free_clr;    // Bits cleared by writeback
    logic [`BT_PREG_NUM-1:0] walk_set;    // Bits set again by the walk
    logic [`BT_PREG_NUM-1:0] busy_d;

    assign is_rollback = (rob_state == ROB_ROLLBACK);

    // Both dispatch slots may allocate in one cycle
    always_comb begin
        alloc_set = '0;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (alloc[i].en) begin
                alloc_set[alloc[i].addr] = 1'b1;
            end
        end
    end

    always_comb begin
        free_clr = '0;
        if (free_int.en) begin
            free_clr[free_int.addr] = 1'b1;
        end
        if (free_mem.en) begin
            free_clr[free_mem.addr] = 1'b1;
        end
    end

    // Completed entries already have their result, so they stay free
    always_comb begin
        walk_set = '0;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (walk[i].valid && !walk[i].complete) begin
                walk_set[walk[i].prd] = 1'b1;
            end
        end
    end

    // Later update wins on the same address
    // Alloc first, then free, then walk
    assign busy_d = ((busy_q | alloc_set) & ~free_clr) | walk_set;

    always_ff @(posedge clock) begin
        if (rst || is_rollback) begin
            busy_q <= '0;  // Rollback acts like a synchronous clear
        end else begin
            busy_q <= busy_d;
        end
    end

endmodule

// File: hw/busy_read_port.sv
`include "busy_track_settings.svh"

module busy_read_port (
    input  busy_track_pkg::src_query_t                query,
    input  logic [`BT_PREG_NUM-1:0]                   busy_q,
    input  busy_track_pkg::preg_upd_t [`BT_SLOTS-1:0] alloc,
    input  busy_track_pkg::preg_upd_t                 free_int,
    input  busy_track_pkg::preg_upd_t                 free_mem,
    output logic                                      busy
);
    import busy_track_pkg::*;

    logic alloc_hit;   // Same-cycle rename of this register
    logic free_hit;    // Same-cycle writeback of this register
    logic stored_bit;

    always_comb begin
        alloc_hit = 1'b0;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (alloc[i].en && (alloc[i].addr == query.addr)) begin
                alloc_hit = 1'b1;
            end
        end
    end

    assign free_hit = (free_int.en && (free_int.addr == query.addr)) ||
                      (free_mem.en && (free_mem.addr == query.addr));

    assign stored_bit = busy_q[query.addr];

    // Allocate beats free beats stored value
    // Walk and rollback only show up a cycle later through busy_q
    always_comb begin
        if (alloc_hit) begin
            busy = 1'b1;
        end else if (free_hit) begin
            busy = 1'b0;
        end else begin
            busy = stored_bit;
        end
    end

endmodule

// File: hw/operand_ready.sv
`include "busy_track_settings.svh"

module operand_ready (
    input  busy_track_pkg::disp_slot_t [`BT_SLOTS-1:0] slot,
    input  logic [2*`BT_SLOTS-1:0]                     src_busy,
    output logic [`BT_SLOTS-1:0]                       slot_ready
);
    import busy_track_pkg::*;

    localparam int SRC_NUM = 2 * `BT_SLOTS;

    logic [SRC_NUM-1:0] src_use;    // Same order as src_busy
    logic [SRC_NUM-1:0] src_block;  // Used and still busy

    // Source order is rs1 then rs2 for each slot
    always_comb begin
        for (int s = 0; s < `BT_SLOTS; s++) begin
            src_use[2*s]   = slot[s].rs1_use;
            src_use[2*s+1] = slot[s].rs2_use;
        end
    end

    // Unused sources never hold a slot back
    assign src_block = src_use & src_busy;

    always_comb begin
        for (int s = 0; s < `BT_SLOTS; s++) begin
            slot_ready[s] = slot[s].valid &&
                            !src_block[2*s] &&
                            !src_block[2*s+1];
        end
    end

endmodule

// File: hw/busy_track_top.sv
`include "busy_track_settings.svh"

module busy_track_top (
    input  logic                                       clock,
    input  logic                                       rst,
    input  busy_track_pkg::preg_upd_t  [`BT_SLOTS-1:0] alloc,
    input  busy_track_pkg::preg_upd_t                  free_int,
    input  busy_track_pkg::preg_upd_t                  free_mem,
    input  busy_track_pkg::rob_state_e                 rob_state,
    input  busy_track_pkg::walk_ent_t  [`BT_SLOTS-1:0] walk,
    input  busy_track_pkg::disp_slot_t [`BT_SLOTS-1:0] slot,
    output logic [2*`BT_SLOTS-1:0]                     src_busy,
    output logic [`BT_SLOTS-1:0]                       slot_ready
);
    import busy_track_pkg::*;

    localparam int SRC_NUM = 2 * `BT_SLOTS;

    logic [`BT_PREG_NUM-1:0] busy_q;
    src_query_t              query [SRC_NUM];

    busy_vector u_busy_vector (
        .clock     (clock),
        .rst       (rst),
        .alloc     (alloc),
        .free_int  (free_int),
        .free_mem  (free_mem),
        .rob_state (rob_state),
        .walk      (walk),
        .busy_q    (busy_q)
    );

    // Ports 0 and 1 serve slot 0, ports 2 and 3 serve slot 1
    for (genvar p = 0; p < SRC_NUM; p++) begin : g_port
        localparam int SLOT_IDX = p / 2;

        if (p % 2 == 0) begin : g_rs1
            assign query[p].addr = slot[SLOT_IDX].rs1;
        end else begin : g_rs2
            assign query[p].addr = slot[SLOT_IDX].rs2;
        end

        busy_read_port u_read_port (
            .query    (query[p]),
            .busy_q   (busy_q),
            .alloc    (alloc),
            .free_int (free_int),
            .free_mem (free_mem),
            .busy     (src_busy[p])
        );
    end

    operand_ready u_operand_ready (
        .slot       (slot),
        .src_busy   (src_busy),
        .slot_ready (slot_ready)
    );

endmodule

// File: dv/busy_track_props.sv
`include "busy_track_settings.svh"

module busy_track_props (
    input  logic                                      clock,
    input  logic                                      rst,
    input  busy_track_pkg::preg_upd_t [`BT_SLOTS-1:0] alloc,
    input  busy_track_pkg::rob_state_e                rob_state,
    input  busy_track_pkg::walk_ent_t [`BT_SLOTS-1:0] walk,
    input  logic [`BT_PREG_NUM-1:0]                   busy_q
);
    timeunit 1ns;
    timeprecision 1ps;

    import busy_track_pkg::*;

    logic [`BT_PREG_NUM-1:0] alloc_set;
    logic [`BT_PREG_NUM-1:0] walk_set;   // Incomplete walked entries only

    always_comb begin
        alloc_set = '0;
        walk_set  = '0;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (alloc[i].en) begin
                alloc_set[alloc[i].addr] = 1'b1;
            end
            if (walk[i].valid && !walk[i].complete) begin
                walk_set[walk[i].prd] = 1'b1;
            end
        end
    end

    a_clear: assert property (@(posedge clock)
        (rst || rob_state == ROB_ROLLBACK) |=> (busy_q == '0))
        else $error("busy table not empty after reset or rollback");

    // Walk has the last word on its address
    a_walk_set: assert property (@(posedge clock) disable iff (rst)
        (rob_state != ROB_ROLLBACK) |=> ((busy_q & $past(walk_set)) == $past(walk_set)))
        else $error("walked incomplete entry not marked busy");

    a_no_stray_rise: assert property (@(posedge clock) disable iff (rst)
        (rob_state != ROB_ROLLBACK) |=>
        ((busy_q & ~$past(busy_q) & ~$past(alloc_set | walk_set)) == '0))
        else $error("busy bit rose without an allocate or walk");

endmodule

bind busy_vector busy_track_props u_props (
    .clock     (clock),
    .rst       (rst),
    .alloc     (alloc),
    .rob_state (rob_state),
    .walk      (walk),
    .busy_q    (busy_q)
);

// File: dv/busy_track_checker.sv
`include "busy_track_settings.svh"

module busy_track_checker (
    input  logic                    clock,
    input  logic                    rst,
    input  logic [2*`BT_SLOTS-1:0]  src_busy,
    input  logic [2*`BT_SLOTS-1:0]  exp_src_busy,
    input  logic [`BT_SLOTS-1:0]    slot_ready,
    input  logic [`BT_SLOTS-1:0]    exp_slot_ready,
    input  logic [`BT_PREG_NUM-1:0] stored,   // Storage inside the DUT
    input  logic [`BT_PREG_NUM-1:0] shadow,   // Reference copy of the storage
    output int                      check_count,
    output int                      error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SRC_NUM = 2 * `BT_SLOTS;

    int n_checks = 0;
    int n_errors = 0;

    assign check_count = n_checks;
    assign error_count = n_errors;

    task automatic compare_bit(
        input string name,
        input int    idx,
        input logic  exp_v,
        input logic  got_v
    );
        n_checks = n_checks + 1;
        if (got_v !== exp_v) begin
            n_errors = n_errors + 1;
            $display("CHECK FAILED at %0t: %s[%0d] expected %b, got %b",
                     $time, name, idx, exp_v, got_v);
        end
    endtask

    // Inputs change on the rising edge, so mid-cycle everything has settled
    always @(negedge clock) begin
        if (!rst) begin
            for (int p = 0; p < SRC_NUM; p++) begin
                compare_bit("src_busy", p, exp_src_busy[p], src_busy[p]);
            end
            for (int s = 0; s < `BT_SLOTS; s++) begin
                compare_bit("slot_ready", s, exp_slot_ready[s], slot_ready[s]);
            end
            n_checks = n_checks + 1;
            if (stored !== shadow) begin
                n_errors = n_errors + 1;
                $display("CHECK FAILED at %0t: busy_q expected %h, got %h",
                         $time, shadow, stored);
            end
        end
    end

endmodule

// File: dv/busy_track_tb.sv
`include "busy_track_settings.svh"

module busy_track_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import busy_track_pkg::*;

    localparam int SRC_NUM    = 2 * `BT_SLOTS;
    localparam int TICK_LIMIT = 8;   // Cycles allowed for one checker sample

    logic                       clock;
    logic                       rst;
    preg_upd_t  [`BT_SLOTS-1:0] alloc;
    preg_upd_t                  free_int;
    preg_upd_t                  free_mem;
    rob_state_e                 rob_state;
    walk_ent_t  [`BT_SLOTS-1:0] walk;
    disp_slot_t [`BT_SLOTS-1:0] slot;
    logic [SRC_NUM-1:0]         src_busy;
    logic [`BT_SLOTS-1:0]       slot_ready;

    logic [`BT_PREG_NUM-1:0] shadow;   // Reference busy table
    logic [SRC_NUM-1:0]      exp_src_busy;
    logic [`BT_SLOTS-1:0]    exp_slot_ready;

    int check_count;
    int error_count;
    int base_checks;
    int base_errors;
    int seed = 32'h52636c28;
    bit stalled = 1'b0;   // Checker stopped sampling

    initial clock = 1'b0;
    always #10 clock = ~clock;

    busy_track_top u_dut (
        .clock      (clock),
        .rst        (rst),
        .alloc      (alloc),
        .free_int   (free_int),
        .free_mem   (free_mem),
        .rob_state  (rob_state),
        .walk       (walk),
        .slot       (slot),
        .src_busy   (src_busy),
        .slot_ready (slot_ready)
    );

    busy_track_checker u_checker (
        .clock          (clock),
        .rst            (rst),
        .src_busy       (src_busy),
        .exp_src_busy   (exp_src_busy),
        .slot_ready     (slot_ready),
        .exp_slot_ready (exp_slot_ready),
        .stored         (u_dut.u_busy_vector.busy_q),
        .shadow         (shadow),
        .check_count    (check_count),
        .error_count    (error_count)
    );

    // Updates taken in order so a later one overrides an earlier one
    function automatic logic [`BT_PREG_NUM-1:0] ref_next(
        input logic [`BT_PREG_NUM-1:0]   cur,
        input preg_upd_t [`BT_SLOTS-1:0] a,
        input preg_upd_t                 fi,
        input preg_upd_t                 fm,
        input walk_ent_t [`BT_SLOTS-1:0] w
    );
        logic [`BT_PREG_NUM-1:0] nxt;
        nxt = cur;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (a[i].en) nxt[a[i].addr] = 1'b1;
        end
        if (fi.en) nxt[fi.addr] = 1'b0;
        if (fm.en) nxt[fm.addr] = 1'b0;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (w[i].valid && !w[i].complete) nxt[w[i].prd] = 1'b1;
        end
        return nxt;
    endfunction

    function automatic logic ref_lookup(
        input logic [`BT_PREG_NUM-1:0]   cur,
        input logic [`BT_PREG_W-1:0]     addr,
        input preg_upd_t [`BT_SLOTS-1:0] a,
        input preg_upd_t                 fi,
        input preg_upd_t                 fm
    );
        logic result;
        result = cur[addr];
        if ((fi.en && fi.addr == addr) || (fm.en && fm.addr == addr)) result = 1'b0;
        for (int i = 0; i < `BT_SLOTS; i++) begin
            if (a[i].en && a[i].addr == addr) result = 1'b1;   // Rename wins
        end
        return result;
    endfunction

    function automatic logic ref_ready(
        input disp_slot_t                s,
        input logic [`BT_PREG_NUM-1:0]   cur,
        input preg_upd_t [`BT_SLOTS-1:0] a,
        input preg_upd_t                 fi,
        input preg_upd_t                 fm
    );
        logic b1;
        logic b2;
        b1 = ref_lookup(cur, s.rs1, a, fi, fm);
        b2 = ref_lookup(cur, s.rs2, a, fi, fm);
        return s.valid && !(s.rs1_use && b1) && !(s.rs2_use && b2);
    endfunction

    always @(posedge clock) begin
        if (rst || rob_state == ROB_ROLLBACK) begin
            shadow <= '0;
        end else begin
            shadow <= ref_next(shadow, alloc, free_int, free_mem, walk);
        end
    end

    always_comb begin
        for (int s = 0; s < `BT_SLOTS; s++) begin
            exp_src_busy[2*s]   = ref_lookup(shadow, slot[s].rs1, alloc, free_int, free_mem);
            exp_src_busy[2*s+1] = ref_lookup(shadow, slot[s].rs2, alloc, free_int, free_mem);
            exp_slot_ready[s]   = ref_ready(slot[s], shadow, alloc, free_int, free_mem);
        end
    end

    function automatic preg_upd_t strobe(input logic en, input logic [`BT_PREG_W-1:0] addr);
        preg_upd_t u;
        u.en   = en;
        u.addr = addr;
        return u;
    endfunction

    function automatic walk_ent_t walk_entry(
        input logic                  valid,
        input logic                  complete,
        input logic [`BT_PREG_W-1:0] prd
    );
        walk_ent_t e;
        e.valid    = valid;
        e.complete = complete;
        e.prd      = prd;
        return e;
    endfunction

    function automatic disp_slot_t dispatch_slot(
        input logic                  valid,
        input logic                  rs1_use,
        input logic [`BT_PREG_W-1:0] rs1,
        input logic                  rs2_use,
        input logic [`BT_PREG_W-1:0] rs2
    );
        disp_slot_t s;
        s.valid   = valid;
        s.rs1_use = rs1_use;
        s.rs1     = rs1;
        s.rs2_use = rs2_use;
        s.rs2     = rs2;
        return s;
    endfunction

    // True with probability one in 2**k
    function automatic logic hit_one_in(input int k);
        logic [31:0] r;
        logic [31:0] mask;
        r    = $random(seed);
        mask = (32'd1 << k) - 32'd1;
        return (r & mask) == 32'd0;
    endfunction

    function automatic logic [`BT_PREG_W-1:0] rand_addr();
        logic [31:0]           r;
        logic [`BT_PREG_W-1:0] a;
        r = $random(seed);
        a = r[`BT_PREG_W-1:0];
        if (r[31]) a[`BT_PREG_W-1:3] = '0;   // Narrow window so strobes collide
        return a;
    endfunction

    function automatic preg_upd_t rand_strobe(input int k);
        return strobe(hit_one_in(k), rand_addr());
    endfunction

    function automatic walk_ent_t rand_walk();
        return walk_entry(hit_one_in(1), hit_one_in(1), rand_addr());
    endfunction

    function automatic disp_slot_t rand_slot();
        return dispatch_slot(!hit_one_in(2), hit_one_in(1), rand_addr(),
                             hit_one_in(1), rand_addr());
    endfunction

    task automatic idle_inputs();
        alloc     <= '0;
        free_int  <= '0;
        free_mem  <= '0;
        rob_state <= ROB_IDLE;
        walk      <= '0;
    endtask

    // Wait until the checker has sampled the current inputs
    task automatic tick();
        int start;
        int waited;
        start  = check_count;
        waited = 0;
        if (!stalled) begin
            @(posedge clock);
            while (check_count == start && waited < TICK_LIMIT) begin
                waited++;
                @(posedge clock);
            end
            if (check_count == start) begin
                stalled = 1'b1;
                $display("Timeout: checker took no sample in %0d cycles", TICK_LIMIT);
            end
        end
    endtask

    task automatic start_test();
        base_checks = check_count;
        base_errors = error_count;
    endtask

    task automatic end_test(input string name);
        $display("Test %s done: %0d checks, %0d errors", name,
                 check_count - base_checks, error_count - base_errors);
    endtask

    initial begin
        logic [`BT_PREG_W-1:0] r;
        logic [`BT_PREG_W-1:0] prd0;
        logic [`BT_PREG_W-1:0] prd1;
        logic [`BT_PREG_W-1:0] prev0;
        logic [`BT_PREG_W-1:0] prev1;

        rst  <= 1'b1;
        slot <= '0;
        idle_inputs();
        repeat (4) @(posedge clock);
        rst <= 1'b0;

        start_test();
        for (int i = 0; i < 8; i++) begin
            slot[0] <= rand_slot();
            slot[1] <= rand_slot();
            tick();
        end
        end_test("reset state");

        start_test();
        for (int i = 0; i < 6; i++) begin
            r = rand_addr();
            slot[0]  <= dispatch_slot(1'b1, 1'b1, r, 1'b1, r);
            slot[1]  <= dispatch_slot(1'b1, 1'b1, r, 1'b0, rand_addr());
            alloc[0] <= strobe(1'b1, r);
            tick();
            alloc[0] <= '0;   // Now only storage holds it
            tick();
            if ((i % 2) == 0) free_int <= strobe(1'b1, r);
            else free_mem <= strobe(1'b1, r);
            tick();
            idle_inputs();
            tick();
        end
        end_test("allocate then free");

        start_test();
        for (int i = 0; i < 6; i++) begin
            r = rand_addr();
            slot[0] <= dispatch_slot(1'b1, 1'b1, r, 1'b0, r);
            slot[1] <= dispatch_slot(1'b1, 1'b0, r, 1'b1, r);
            if ((i % 2) == 0) begin
                alloc[0] <= strobe(1'b1, r);
                free_int <= strobe(1'b1, r);
            end else begin
                alloc[1] <= strobe(1'b1, r);
                free_mem <= strobe(1'b1, r);
            end
            tick();
            idle_inputs();
            tick();
        end
        end_test("bypass priority");

        start_test();
        for (int i = 0; i < 10; i++) begin
            prev0 = rand_addr();
            prev1 = rand_addr();
            alloc[0] <= strobe(1'b1, prev0);
            alloc[1] <= strobe(1'b1, prev1);
            slot[0]  <= rand_slot();
            slot[1]  <= rand_slot();
            tick();
        end
        idle_inputs();
        rob_state <= ROB_ROLLBACK;
        tick();
        rob_state <= ROB_WALK;
        for (int i = 0; i < 8; i++) begin
            prd0 = rand_addr();
            prd1 = rand_addr();
            walk[0] <= walk_entry(hit_one_in(1), hit_one_in(1), prd0);
            walk[1] <= walk_entry(hit_one_in(1), hit_one_in(1), prd1);
            slot[0] <= dispatch_slot(1'b1, 1'b1, prev0, 1'b1, prev1);
            slot[1] <= dispatch_slot(1'b1, 1'b1, prd0, 1'b1, prd1);
            tick();
            prev0 = prd0;
            prev1 = prd1;
        end
        idle_inputs();
        slot[0] <= dispatch_slot(1'b1, 1'b1, prev0, 1'b1, prev1);
        tick();
        end_test("rollback and walk");

        start_test();
        idle_inputs();
        for (int i = 0; i < 40; i++) begin
            slot[0]  <= rand_slot();
            slot[1]  <= rand_slot();
            alloc[0] <= rand_strobe(2);
            free_int <= rand_strobe(2);
            tick();
        end
        end_test("slot readiness");

        start_test();
        for (int i = 0; i < 400; i++) begin
            slot[0]  <= rand_slot();
            slot[1]  <= rand_slot();
            free_int <= rand_strobe(1);
            free_mem <= rand_strobe(2);
            if (hit_one_in(5)) begin
                rob_state <= ROB_ROLLBACK;
                alloc     <= '0;
                walk      <= '0;
            end else if (hit_one_in(3)) begin
                rob_state <= ROB_WALK;   // Dispatch holds off during recovery
                alloc     <= '0;
                walk[0]   <= rand_walk();
                walk[1]   <= rand_walk();
            end else begin
                rob_state <= ROB_IDLE;
                alloc[0]  <= rand_strobe(1);
                alloc[1]  <= rand_strobe(1);
                walk      <= '0;
            end
            tick();
        end
        idle_inputs();
        end_test("random mix");

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && !stalled) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: busy_track.f
+incdir+hw
hw/busy_track_pkg.sv
hw/busy_vector.sv
hw/busy_read_port.sv
hw/operand_ready.sv
hw/busy_track_top.sv
dv/busy_track_props.sv
dv/busy_track_checker.sv
dv/busy_track_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the busy table testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module busy_track_tb \
    --Mdir obj_dir \
    -o busy_track_sim \
    -f busy_track.f

# A failed assertion ends the run early and leaves no pass line in the log
./obj_dir/busy_track_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
fi

echo "Simulation result: FAIL"
exit 1
